// File: hw/regmgr_pkg.sv
// register manager constants
package regmgr_pkg;

   localparam int ADDR_W = 5;  // register address width.
   localparam int DATA_W = 32; // register data width.
   localparam int N_REGS = 32; // registers in each bank.

   // one write port and one queue stage per execution unit.
   // chain order is misc, alu, mem, fpu.
   localparam int N_WRITE_PORTS = 4;

   // entries still in flight that a read must see: the gather registers,
   // then the skid slots, then the stage output registers.
   localparam int N_PENDING = 3 * N_WRITE_PORTS;

   // base slot of each group in the flattened pending vectors.
   // a lower slot wins the forwarding search.
   localparam int PEND_GATHER = 0;
   localparam int PEND_SKID   = N_WRITE_PORTS;
   localparam int PEND_STAGE  = 2 * N_WRITE_PORTS;

endpackage

// File: hw/write_entry_if.sv
`timescale 1ns/1ps
// write entry link
interface write_entry_if;
   import regmgr_pkg::*;

   logic              valid;    // plain strobe, consumed in the same cycle.
   logic [ADDR_W-1:0] addr;
   logic              is_float; // selects the float bank.
   logic [DATA_W-1:0] data;

   modport src (
      output valid,
      output addr,
      output is_float,
      output data
   );

   modport dst (
      input valid,
      input addr,
      input is_float,
      input data
   );

endinterface

// File: hw/write_port_gather.sv
`timescale 1ns/1ps
// unit write port registers
module write_port_gather (
   input  logic                                             clk,
   input  logic                                             reset,
   input  logic                                             wr_en_misc,
   input  logic [regmgr_pkg::ADDR_W-1:0]                    wr_addr_misc,
   input  logic                                             wr_float_misc,
   input  logic [regmgr_pkg::DATA_W-1:0]                    wr_data_misc,
   input  logic                                             wr_en_alu,
   input  logic [regmgr_pkg::ADDR_W-1:0]                    wr_addr_alu,
   input  logic                                             wr_float_alu,
   input  logic [regmgr_pkg::DATA_W-1:0]                    wr_data_alu,
   input  logic                                             wr_en_mem,
   input  logic [regmgr_pkg::ADDR_W-1:0]                    wr_addr_mem,
   input  logic                                             wr_float_mem,
   input  logic [regmgr_pkg::DATA_W-1:0]                    wr_data_mem,
   input  logic                                             wr_en_fpu,
   input  logic [regmgr_pkg::ADDR_W-1:0]                    wr_addr_fpu,
   input  logic                                             wr_float_fpu,
   input  logic [regmgr_pkg::DATA_W-1:0]                    wr_data_fpu,
   write_entry_if.src                                       gathered [regmgr_pkg::N_WRITE_PORTS],
   output logic [regmgr_pkg::N_WRITE_PORTS-1:0]             pend_valid,
   output logic [regmgr_pkg::N_WRITE_PORTS*regmgr_pkg::ADDR_W-1:0] pend_addr,
   output logic [regmgr_pkg::N_WRITE_PORTS-1:0]             pend_float,
   output logic [regmgr_pkg::N_WRITE_PORTS*regmgr_pkg::DATA_W-1:0] pend_data
);
   import regmgr_pkg::*;

   logic [N_WRITE_PORTS-1:0] en_in;
   logic [N_WRITE_PORTS-1:0] float_in;
   logic [ADDR_W-1:0]        addr_in [N_WRITE_PORTS];
   logic [DATA_W-1:0]        data_in [N_WRITE_PORTS];
   logic [N_WRITE_PORTS-1:0] valid_q;
   logic [N_WRITE_PORTS-1:0] float_q;
   logic [ADDR_W-1:0]        addr_q [N_WRITE_PORTS];
   logic [DATA_W-1:0]        data_q [N_WRITE_PORTS];

   // index k follows the chain order, misc first.
   assign en_in    = {wr_en_fpu, wr_en_mem, wr_en_alu, wr_en_misc};
   assign float_in = {wr_float_fpu, wr_float_mem, wr_float_alu, wr_float_misc};
   assign addr_in  = '{wr_addr_misc, wr_addr_alu, wr_addr_mem, wr_addr_fpu};
   assign data_in  = '{wr_data_misc, wr_data_alu, wr_data_mem, wr_data_fpu};

   always_ff @(posedge clk) begin
      if (reset) begin
         valid_q <= '0;
      end else begin
         valid_q <= en_in;
      end
   end

   always_ff @(posedge clk) begin
      float_q <= float_in;
      addr_q  <= addr_in;
      data_q  <= data_in;
   end

   for (genvar k = 0; k < N_WRITE_PORTS; k++) begin : g_port
      assign gathered[k].valid    = valid_q[k];
      assign gathered[k].addr     = addr_q[k];
      assign gathered[k].is_float = float_q[k];
      assign gathered[k].data     = data_q[k];
      assign pend_addr[k*ADDR_W +: ADDR_W] = addr_q[k];
      assign pend_data[k*DATA_W +: DATA_W] = data_q[k];
   end

   assign pend_valid = valid_q;
   assign pend_float = float_q;

endmodule

// File: hw/write_queue_stage.sv
`timescale 1ns/1ps
// write queue merge stage
module write_queue_stage (
   input  logic                          clk,
   input  logic                          reset,
   write_entry_if.dst                    local_in,
   write_entry_if.dst                    up,
   write_entry_if.src                    down,
   output logic                          skid_valid,
   output logic [regmgr_pkg::ADDR_W-1:0] skid_addr,
   output logic                          skid_float,
   output logic [regmgr_pkg::DATA_W-1:0] skid_data,
   output logic                          overflow
);
   import regmgr_pkg::*;

   logic              out_valid;
   logic [ADDR_W-1:0] out_addr;
   logic              out_float;
   logic [DATA_W-1:0] out_data;
   logic              skid_load;
   logic              lost;

   // the local entry parks when upstream takes the output and the slot is free,
   // or when the slot drains to the output in the same cycle.
   assign skid_load = local_in.valid && (up.valid ? !skid_valid : skid_valid);
   assign lost      = local_in.valid && up.valid && skid_valid; // nowhere left to go.

   always_ff @(posedge clk) begin
      if (reset) begin
         out_valid <= 1'b0;
      end else begin
         out_valid <= up.valid || skid_valid || local_in.valid;
      end
   end

   // upstream first, then the parked entry, then the local port.
   always_ff @(posedge clk) begin
      if (up.valid) begin
         out_addr  <= up.addr;
         out_float <= up.is_float;
         out_data  <= up.data;
      end else if (skid_valid) begin
         out_addr  <= skid_addr;
         out_float <= skid_float;
         out_data  <= skid_data;
      end else begin
         out_addr  <= local_in.addr;
         out_float <= local_in.is_float;
         out_data  <= local_in.data;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         skid_valid <= 1'b0;
      end else begin
         skid_valid <= skid_load || (skid_valid && up.valid); // held while upstream is busy.
      end
   end

   always_ff @(posedge clk) begin
      if (skid_load) begin
         skid_addr  <= local_in.addr;
         skid_float <= local_in.is_float;
         skid_data  <= local_in.data;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         overflow <= 1'b0;
      end else if (lost) begin
         overflow <= 1'b1; // sticky until reset.
      end
   end

   assign down.valid    = out_valid;
   assign down.addr     = out_addr;
   assign down.is_float = out_float;
   assign down.data     = out_data;

endmodule

// File: hw/register_banks.sv
`timescale 1ns/1ps
// int and float register banks
module register_banks (
   input  logic                          clk,
   input  logic                          reset,
   write_entry_if.dst                    drain,
   input  logic [regmgr_pkg::ADDR_W-1:0] rs_addr,
   input  logic [regmgr_pkg::ADDR_W-1:0] rt_addr,
   output logic [regmgr_pkg::DATA_W-1:0] int_rs,
   output logic [regmgr_pkg::DATA_W-1:0] int_rt,
   output logic [regmgr_pkg::DATA_W-1:0] float_rs,
   output logic [regmgr_pkg::DATA_W-1:0] float_rt
);
   import regmgr_pkg::*;

   logic [DATA_W-1:0] int_bank [N_REGS];
   logic [DATA_W-1:0] float_bank [N_REGS];
   logic              int_we;
   logic              float_we;

   // int register 0 is hardwired, so its writes are dropped here.
   assign int_we   = drain.valid && !drain.is_float && (drain.addr != '0);
   assign float_we = drain.valid && drain.is_float;

   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < N_REGS; i++) begin
            int_bank[i] <= '0;
         end
      end else if (int_we) begin
         int_bank[drain.addr] <= drain.data;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < N_REGS; i++) begin
            float_bank[i] <= '0;
         end
      end else if (float_we) begin
         float_bank[drain.addr] <= drain.data;
      end
   end

   // asynchronous reads, the address is already registered by the reader.
   assign int_rs   = int_bank[rs_addr];
   assign int_rt   = int_bank[rt_addr];
   assign float_rs = float_bank[rs_addr];
   assign float_rt = float_bank[rt_addr];

endmodule

// File: hw/operand_read.sv
`timescale 1ns/1ps
// operand read port with forwarding
module operand_read (
   input  logic                                              clk,
   input  logic                                              reset,
   input  logic [regmgr_pkg::ADDR_W-1:0]                     addr,
   input  logic                                              is_float,
   output logic [regmgr_pkg::ADDR_W-1:0]                     addr_q,
   input  logic [regmgr_pkg::N_PENDING-1:0]                  pend_valid,
   input  logic [regmgr_pkg::N_PENDING*regmgr_pkg::ADDR_W-1:0] pend_addr,
   input  logic [regmgr_pkg::N_PENDING-1:0]                  pend_float,
   input  logic [regmgr_pkg::N_PENDING*regmgr_pkg::DATA_W-1:0] pend_data,
   input  logic [regmgr_pkg::DATA_W-1:0]                     bank_int,
   input  logic [regmgr_pkg::DATA_W-1:0]                     bank_float,
   output logic [regmgr_pkg::DATA_W-1:0]                     data
);
   import regmgr_pkg::*;

   logic              float_q;
   logic              found;
   logic [DATA_W-1:0] hit_data;
   logic              is_zero_reg;

   // after reset this selects int register 0, so data reads zero.
   always_ff @(posedge clk) begin
      if (reset) begin
         addr_q  <= '0;
         float_q <= 1'b0;
      end else begin
         addr_q  <= addr;
         float_q <= is_float;
      end
   end

   // the lowest matching slot wins, which gives gather, skid, stage order.
   always_comb begin
      found    = 1'b0;
      hit_data = '0;
      for (int i = 0; i < N_PENDING; i++) begin
         if (!found && pend_valid[i] &&
             (pend_addr[i*ADDR_W +: ADDR_W] == addr_q) &&
             (pend_float[i] == float_q)) begin
            found    = 1'b1;
            hit_data = pend_data[i*DATA_W +: DATA_W];
         end
      end
   end

   assign is_zero_reg = !float_q && (addr_q == '0);

   always_comb begin
      if (is_zero_reg) begin
         data = '0; // a pending write to int register 0 must not leak through.
      end else if (found) begin
         data = hit_data;
      end else if (float_q) begin
         data = bank_float;
      end else begin
         data = bank_int;
      end
   end

endmodule

// File: hw/register_manager.sv
`timescale 1ns/1ps
// register manager top
module register_manager (
   input  logic                          clk,
   input  logic                          reset,
   input  logic [regmgr_pkg::ADDR_W-1:0] rs_addr,
   input  logic [regmgr_pkg::ADDR_W-1:0] rt_addr,
   input  logic                          rs_float,
   input  logic                          rt_float,
   output logic [regmgr_pkg::DATA_W-1:0] rs_data,
   output logic [regmgr_pkg::DATA_W-1:0] rt_data,
   input  logic                          wr_en_misc,
   input  logic [regmgr_pkg::ADDR_W-1:0] wr_addr_misc,
   input  logic                          wr_float_misc,
   input  logic [regmgr_pkg::DATA_W-1:0] wr_data_misc,
   input  logic                          wr_en_alu,
   input  logic [regmgr_pkg::ADDR_W-1:0] wr_addr_alu,
   input  logic                          wr_float_alu,
   input  logic [regmgr_pkg::DATA_W-1:0] wr_data_alu,
   input  logic                          wr_en_mem,
   input  logic [regmgr_pkg::ADDR_W-1:0] wr_addr_mem,
   input  logic                          wr_float_mem,
   input  logic [regmgr_pkg::DATA_W-1:0] wr_data_mem,
   input  logic                          wr_en_fpu,
   input  logic [regmgr_pkg::ADDR_W-1:0] wr_addr_fpu,
   input  logic                          wr_float_fpu,
   input  logic [regmgr_pkg::DATA_W-1:0] wr_data_fpu,
   output logic                          write_overflow
);
   import regmgr_pkg::*;

   write_entry_if gathered [N_WRITE_PORTS] ();
   write_entry_if link [N_WRITE_PORTS+1] ();

   logic [N_PENDING-1:0]        pend_valid;
   logic [N_PENDING*ADDR_W-1:0] pend_addr;
   logic [N_PENDING-1:0]        pend_float;
   logic [N_PENDING*DATA_W-1:0] pend_data;
   logic [N_WRITE_PORTS-1:0]    stage_overflow;
   logic [ADDR_W-1:0]           rs_addr_q, rt_addr_q;
   logic [DATA_W-1:0]           int_rs, int_rt, float_rs, float_rt;

   write_port_gather i_write_port_gather (
      .clk(clk), .reset(reset),
      .wr_en_misc(wr_en_misc), .wr_addr_misc(wr_addr_misc),
      .wr_float_misc(wr_float_misc), .wr_data_misc(wr_data_misc),
      .wr_en_alu(wr_en_alu), .wr_addr_alu(wr_addr_alu),
      .wr_float_alu(wr_float_alu), .wr_data_alu(wr_data_alu),
      .wr_en_mem(wr_en_mem), .wr_addr_mem(wr_addr_mem),
      .wr_float_mem(wr_float_mem), .wr_data_mem(wr_data_mem),
      .wr_en_fpu(wr_en_fpu), .wr_addr_fpu(wr_addr_fpu),
      .wr_float_fpu(wr_float_fpu), .wr_data_fpu(wr_data_fpu),
      .gathered(gathered),
      .pend_valid(pend_valid[PEND_GATHER +: N_WRITE_PORTS]),
      .pend_addr(pend_addr[PEND_GATHER*ADDR_W +: N_WRITE_PORTS*ADDR_W]),
      .pend_float(pend_float[PEND_GATHER +: N_WRITE_PORTS]),
      .pend_data(pend_data[PEND_GATHER*DATA_W +: N_WRITE_PORTS*DATA_W])
   );

   // nothing enters above the first stage.
   assign link[0].valid    = 1'b0;
   assign link[0].addr     = '0;
   assign link[0].is_float = 1'b0;
   assign link[0].data     = '0;

   for (genvar k = 0; k < N_WRITE_PORTS; k++) begin : g_stage
      write_queue_stage i_write_queue_stage (
         .clk(clk), .reset(reset),
         .local_in(gathered[k]), .up(link[k]), .down(link[k+1]),
         .skid_valid(pend_valid[PEND_SKID+k]),
         .skid_addr(pend_addr[(PEND_SKID+k)*ADDR_W +: ADDR_W]),
         .skid_float(pend_float[PEND_SKID+k]),
         .skid_data(pend_data[(PEND_SKID+k)*DATA_W +: DATA_W]),
         .overflow(stage_overflow[k])
      );
      assign pend_valid[PEND_STAGE+k]                    = link[k+1].valid;
      assign pend_addr[(PEND_STAGE+k)*ADDR_W +: ADDR_W]  = link[k+1].addr;
      assign pend_float[PEND_STAGE+k]                    = link[k+1].is_float;
      assign pend_data[(PEND_STAGE+k)*DATA_W +: DATA_W]  = link[k+1].data;
   end

   register_banks i_register_banks (
      .clk(clk), .reset(reset), .drain(link[N_WRITE_PORTS]),
      .rs_addr(rs_addr_q), .rt_addr(rt_addr_q),
      .int_rs(int_rs), .int_rt(int_rt), .float_rs(float_rs), .float_rt(float_rt)
   );

   operand_read i_operand_read_rs (
      .clk(clk), .reset(reset), .addr(rs_addr), .is_float(rs_float), .addr_q(rs_addr_q),
      .pend_valid(pend_valid), .pend_addr(pend_addr),
      .pend_float(pend_float), .pend_data(pend_data),
      .bank_int(int_rs), .bank_float(float_rs), .data(rs_data)
   );

   operand_read i_operand_read_rt (
      .clk(clk), .reset(reset), .addr(rt_addr), .is_float(rt_float), .addr_q(rt_addr_q),
      .pend_valid(pend_valid), .pend_addr(pend_addr),
      .pend_float(pend_float), .pend_data(pend_data),
      .bank_int(int_rt), .bank_float(float_rt), .data(rt_data)
   );

   assign write_overflow = |stage_overflow; // each stage flag is already sticky.

endmodule

// File: dv/register_manager_tb.sv
// register manager testbench
`timescale 1ns/1ps
module register_manager_tb;
   import regmgr_pkg::*;

   localparam int TRACE_FIELDS = 22; // four writes of four fields, two reads, two flags.
   localparam int MAX_LINES    = 1000;
   localparam int OVF_TIMEOUT  = 40;

   logic                     clk;
   logic                     reset;
   logic [ADDR_W-1:0]        rs_addr;
   logic [ADDR_W-1:0]        rt_addr;
   logic                     rs_float;
   logic                     rt_float;
   logic [DATA_W-1:0]        rs_data;
   logic [DATA_W-1:0]        rt_data;
   logic [N_WRITE_PORTS-1:0] wr_en;
   logic [N_WRITE_PORTS-1:0] wr_float;
   logic [ADDR_W-1:0]        wr_addr [N_WRITE_PORTS];
   logic [DATA_W-1:0]        wr_data [N_WRITE_PORTS];
   logic                     write_overflow;

   logic [DATA_W-1:0] ref_int [N_REGS];
   logic [DATA_W-1:0] ref_float [N_REGS];
   logic [31:0]       rec [TRACE_FIELDS]; // unit k sits at fields 4k to 4k+3.
   logic              check_due;          // compare the reads at the next sample.
   logic              ovf_allowed;
   logic              ovf_seen;
   logic [DATA_W-1:0] exp_rs;
   logic [DATA_W-1:0] exp_rt;
   int                n_checks;
   int                n_errors;

   register_manager i_register_manager (
      .clk(clk), .reset(reset),
      .rs_addr(rs_addr), .rt_addr(rt_addr), .rs_float(rs_float), .rt_float(rt_float),
      .rs_data(rs_data), .rt_data(rt_data),
      .wr_en_misc(wr_en[0]), .wr_addr_misc(wr_addr[0]),
      .wr_float_misc(wr_float[0]), .wr_data_misc(wr_data[0]),
      .wr_en_alu(wr_en[1]), .wr_addr_alu(wr_addr[1]),
      .wr_float_alu(wr_float[1]), .wr_data_alu(wr_data[1]),
      .wr_en_mem(wr_en[2]), .wr_addr_mem(wr_addr[2]),
      .wr_float_mem(wr_float[2]), .wr_data_mem(wr_data[2]),
      .wr_en_fpu(wr_en[3]), .wr_addr_fpu(wr_addr[3]),
      .wr_float_fpu(wr_float[3]), .wr_data_fpu(wr_data[3]),
      .write_overflow(write_overflow)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   task automatic write_model(input logic is_float, input logic [ADDR_W-1:0] addr,
                              input logic [DATA_W-1:0] value);
      if (is_float) begin
         ref_float[addr] = value;
      end else if (addr != '0) begin
         ref_int[addr] = value; // int register 0 stays zero.
      end
   endtask

   function automatic logic [DATA_W-1:0] model_read(input logic is_float,
                                                    input logic [ADDR_W-1:0] addr);
      if (is_float) begin
         return ref_float[addr];
      end
      return ref_int[addr];
   endfunction

   task automatic compare_read(input string port, input logic is_float,
                               input logic [ADDR_W-1:0] addr,
                               input logic [DATA_W-1:0] got, input logic [DATA_W-1:0] want);
      n_checks++;
      assert (got === want) else begin
         n_errors++;
         $display("Error at %0t ns: %s read of %s register %0d is %h, expected %h",
                  $time, port, is_float ? "float" : "int", addr, got, want);
      end
   endtask

   // the read inputs still hold the previous cycle's request here.
   task automatic check_outputs();
      if (check_due) begin
         compare_read("rs", rs_float, rs_addr, rs_data, exp_rs);
         compare_read("rt", rt_float, rt_addr, rt_data, exp_rt);
      end
      if (ovf_seen) begin
         n_checks++;
         assert (write_overflow === 1'b1) else begin
            n_errors++;
            $display("Error at %0t ns: write_overflow fell after it was set", $time);
         end
      end else if (!ovf_allowed) begin
         n_checks++;
         assert (write_overflow === 1'b0) else begin
            n_errors++;
            $display("Error at %0t ns: write_overflow set before any burst traffic", $time);
         end
      end
      if (write_overflow === 1'b1) begin
         ovf_seen = 1'b1;
      end
   endtask

   task automatic clear_record();
      for (int i = 0; i < TRACE_FIELDS; i++) begin
         rec[i] = '0;
      end
   endtask

   // one clock cycle: check what the last cycle asked for, then drive rec.
   task automatic run_cycle();
      @(posedge clk);
      #1;
      check_outputs();
      for (int u = 0; u < N_WRITE_PORTS; u++) begin
         wr_en[u]    = rec[4*u][0];
         wr_float[u] = rec[4*u+1][0];
         wr_addr[u]  = rec[4*u+2][ADDR_W-1:0];
         wr_data[u]  = rec[4*u+3];
         if (wr_en[u]) begin
            write_model(wr_float[u], wr_addr[u], wr_data[u]);
         end
      end
      rs_float    = rec[16][0];
      rs_addr     = rec[17][ADDR_W-1:0];
      rt_float    = rec[18][0];
      rt_addr     = rec[19][ADDR_W-1:0];
      check_due   = rec[20][0];
      ovf_allowed = rec[21][0];
      exp_rs      = model_read(rs_float, rs_addr); // includes this cycle's writes.
      exp_rt      = model_read(rt_float, rt_addr);
   endtask

   initial begin
      int    fd;
      int    code;
      int    n_fields;
      int    n_lines;
      int    waited;
      string line;

      reset    = 1'b1;
      rs_addr  = '0;
      rt_addr  = '0;
      rs_float = 1'b0;
      rt_float = 1'b0;
      wr_en    = '0;
      wr_float = '0;
      for (int u = 0; u < N_WRITE_PORTS; u++) begin
         wr_addr[u] = '0;
         wr_data[u] = '0;
      end
      for (int r = 0; r < N_REGS; r++) begin
         ref_int[r]   = '0;
         ref_float[r] = '0;
      end
      check_due   = 1'b0;
      ovf_allowed = 1'b0;
      ovf_seen    = 1'b0;
      n_checks    = 0;
      n_errors    = 0;
      repeat (16) @(posedge clk);
      #1;
      reset = 1'b0;

      // sweep both banks after reset, int on rs and float on rt.
      for (int r = 0; r < N_REGS; r++) begin
         clear_record();
         rec[17] = r;
         rec[18] = 32'd1;
         rec[19] = r;
         rec[20] = 32'd1;
         run_cycle();
      end

      fd = $fopen("dv/register_trace.txt", "r");
      if (fd == 0) begin
         n_errors++;
         $display("could not open the trace file dv/register_trace.txt");
      end else begin
         n_lines = 0;
         while (!$feof(fd) && n_lines < MAX_LINES) begin
            n_lines++;
            line = "";
            code = $fgets(line, fd);
            if (code != 0) begin
               n_fields = $sscanf(line,
                  "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                  rec[0], rec[1], rec[2], rec[3], rec[4], rec[5], rec[6], rec[7],
                  rec[8], rec[9], rec[10], rec[11], rec[12], rec[13], rec[14], rec[15],
                  rec[16], rec[17], rec[18], rec[19], rec[20], rec[21]);
               if (n_fields == TRACE_FIELDS) begin
                  run_cycle();
               end else if (n_fields > 0) begin
                  n_errors++;
                  $display("trace line %0d has %0d fields instead of %0d",
                           n_lines, n_fields, TRACE_FIELDS);
               end
            end
         end
         $fclose(fd);
      end

      // the burst at the end of the trace must raise the flag, and it must hold.
      clear_record();
      rec[21] = 32'd1;
      waited  = 0;
      while (!ovf_seen && waited < OVF_TIMEOUT) begin
         run_cycle();
         waited++;
      end
      if (!ovf_seen) begin
         n_errors++;
         $display("write_overflow stayed low for %0d cycles after the final burst",
                  OVF_TIMEOUT);
      end else begin
         repeat (8) run_cycle();
      end

      $display("checks: %0d, errors: %0d", n_checks, n_errors);
      if (n_errors == 0) begin
         $display("PASS: all tests");
      end else begin
         $display("FAIL: see errors above");
      end
      $finish;
   end

endmodule

// File: build.f
hw/regmgr_pkg.sv
hw/write_entry_if.sv
hw/write_port_gather.sv
hw/write_queue_stage.sv
hw/register_banks.sv
hw/operand_read.sv
hw/register_manager.sv
dv/register_manager_tb.sv

// File: run.sh
#!/bin/sh
# compile and run the register manager testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log
verilator --binary --timing --assert -f build.f --top-module register_manager_tb \
   -Mdir obj_dir -o register_manager_sim > build.log 2>&1 \
   && ./obj_dir/register_manager_sim > sim.log 2>&1 \
   || echo "build or simulation step failed, see build.log and sim.log"
cat sim.log 2>/dev/null
grep -q "^PASS: all tests$" sim.log 2>/dev/null && exit 0 || exit 1

// File: dv/register_trace.txt
# units misc alu mem fpu, each: en float addr data; then rs: float addr; rt: float addr;
# then chk (compare reads next cycle) and ovf (burst traffic started). all fields hex.
# one write per unit, read at once and in the following cycles
1 0 05 11110005  0 0 00 00000000  0 0 00 00000000  0 0 00 00000000  0 05 1 05  1 0
0 0 00 00000000  1 1 06 22220006  0 0 00 00000000  0 0 00 00000000  0 05 1 06  1 0
0 0 00 00000000  0 0 00 00000000  1 0 07 33330007  0 0 00 00000000  0 07 1 06  1 0
0 0 00 00000000  0 0 00 00000000  0 0 00 00000000  1 1 08 44440008  0 05 1 08  1 0
0 0 00 00000000  0 0 00 00000000  0 0 00 00000000  0 0 00 00000000  0 07 1 08  1 0
0 0 00 00000000  0 0 00 00000000  0 0 00 00000000  0 0 00 00000000  0 05 1 06  1 0
0 0 00 00000000  0 0 00 00000000  0 0 00 00000000  0 0 00 00000000  0 07 1 08  1 0
0 0 00 00000000  0 0 00 00000000  0 0 00 00000000  0 0 00 00000000  0 05 1 06  1 0
0 0 00 00000000  0 0 00 00000000  0 0 00 00000000  0 0 00 00000000  0 06 1 05  1 0
0 0 00 00000000  0 0 00 00000000  0 0 00 00000000  0 0 00 00000000  0 07 1 08  1 0
0 0 00 00000000  0 0 00 00000000  0 0 00 00000000  0 0 00 00000000  1 07 0 08  1 0
# all four units at once, two cycles in a row, then idle
1 0 0a a0a0000a  1 0 0b b1b1000b  1 1 0c c2c2000c  1 1 0d d3d3000d  0 0a 0 0b  1 0
1 1 0e 0e0ee00e  1 0 0f 0f0ff00f  1 0 10 10101010  1 1 11 17171717  1 0c 1 0d  1 0
0 0 00 00000000  0 0 00 00000000  0 0 00 00000000  0 0 00 00000000  1 0e 0 0f  1 0
0 0 00 00000000  0 0 00 00000000  0 0 00 00000000  0 0 00 00000000  0 10 1 11  1 0
0 0 00 00000000  0 0 00 00000000  0 0 00 00000000  0 0 00 00000000  0 0a 1 0c  1 0
0 0 00 00000000  0 0 00 00000000  0 0 00 00000000  0 0 00 00000000  0 0b 1 0d  1 0
0 0 00 00000000  0 0 00 00000000  0 0 00 00000000  0 0 00 00000000  1 0e 0 0f  1 0
0 0 00 00000000  0 0 00 00000000  0 0 00 00000000  0 0 00 00000000  0 10 1 11  1 0
0 0 00 00000000  0 0 00 00000000  0 0 00 00000000  0 0 00 00000000  0 0a 0 0b  1 0
# register 0 in both banks
1 0 00 dead0000  1 1 00 f1000000  0 0 00 00000000  0 0 00 00000000  0 00 1 00  1 0
0 0 00 00000000  0 0 00 00000000  0 0 00 00000000  0 0 00 00000000  0 00 1 00  1 0
0 0 00 00000000  0 0 00 00000000  0 0 00 00000000  0 0 00 00000000  1 00 0 00  1 0
0 0 00 00000000  0 0 00 00000000  0 0 00 00000000  0 0 00 00000000  0 05 1 08  1 0
0 0 00 00000000  0 0 00 00000000  0 0 00 00000000  0 0 00 00000000  0 00 1 00  1 0
# continuous burst on all ports
1 0 14 50000014  1 0 15 51000015  1 0 16 52000016  1 0 17 53000017  0 00 0 00  0 1
1 0 18 54000018  1 0 19 55000019  1 0 1a 5600001a  1 0 1b 5700001b  0 00 0 00  0 1
1 1 14 60000014  1 1 15 61000015  1 1 16 62000016  1 1 17 63000017  0 00 0 00  0 1
1 1 18 64000018  1 1 19 65000019  1 1 1a 6600001a  1 1 1b 6700001b  0 00 0 00  0 1
